// ==== tb_panel_input.txt ====
# S byte: send a byte, R value: expected rgb_enable, B value: expected brightness_enable
# Q: wait until idle, M addr colour: one model address, F colour: every model address
R 7
B 3f
S 02
R 3
S 04
R 1
S 06
R 0
S 03
R 2
S 05
R 3
S 01
R 7
S 11
B 1f
S 16
B 1e
S 13
B 16
S 7f
B 16
R 7
S 10
B 00
S 19
B 3f
S 20
S c5
B 05
S 22
S 5a
Q
F 5a
S 23
S 12
S 9c
Q
M 12 9c
M 11 5a
M 13 5a
S 21
Q
F 00
S 22
S a7
S 23
S 3f
S 3c
Q
M 3f 3c
M 3e a7
M 00 a7

// ==== list.f ====
+incdir+.
panel_cmd_pkg.sv
panel_fb_pkg.sv
cmd_dispatch_if.sv
cmd_decoder.sv
fb_writer.sv
panel_control_top.sv
tb_panel_control.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_panel_control

.PHONY: compile run clean

compile: $(SIM)

$(SIM): list.f *.sv *.svh
	verilator --binary --timing -f list.f --top-module tb_panel_control -o Vtb_panel_control

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== tb_panel_control.sv ====
// testbench for the panel command controller
// file-driven stimulus, framebuffer write model, compare tasks and timeout
`timescale 1ns/1ps
`include "panel_settings.svh"

module tb_panel_control;
    import panel_cmd_pkg::*;
    import panel_fb_pkg::*;

    localparam int FB_SIZE = `PANEL_WIDTH * `PANEL_HEIGHT;

    logic clk_in;
    logic reset;
    cmd_byte_t data_rx;
    logic data_ready_n;
    logic ready_for_data;
    rgb_enable_t rgb_enable;
    brightness_t brightness_enable;
    fb_addr_t ram_address;
    pixel_color_t ram_data;
    logic ram_write_enable;

    pixel_color_t fb_model [0:FB_SIZE-1];
    int quiet_cycles;
    int cycle_count;
    int cycle_limit;
    logic [31:0] rand_state;

    // one entry per record of the stimulus file
    logic [7:0] rec_tag [$];
    logic [7:0] rec_a [$];
    logic [7:0] rec_b [$];
    int rec_line [$];

    panel_control_top u_dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .ready_for_data    (ready_for_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data          (ram_data),
        .ram_write_enable  (ram_write_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // bus outputs are registered, so the falling edge sees them settled
    always @(negedge clk_in) begin
        // the stream is held off on every write cycle of a job and only then
        check_ready($sformatf("ready_for_data on cycle %0d", cycle_count),
                    !ram_write_enable, ready_for_data);
        if (ram_write_enable) begin
            fb_model[ram_address] = ram_data;
            quiet_cycles = 0;
        end else begin
            quiet_cycles = quiet_cycles + 1;
        end
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_rgb(input string name, input rgb_enable_t expected,
                             input rgb_enable_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "rgb_enable mismatch");
        end
    endtask

    task automatic check_brightness(input string name, input brightness_t expected,
                                    input brightness_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "brightness_enable mismatch");
        end
    endtask

    task automatic check_color(input string name, input pixel_color_t expected,
                               input pixel_color_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "framebuffer colour mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic expected,
                               input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "ready_for_data mismatch");
        end
    endtask

    // random gap with the stream idle, then hold the byte until it is taken
    task automatic send_byte(input cmd_byte_t value);
        int idle;
        rand_state = lcg_next(rand_state);
        idle = int'(rand_state[17:16]);
        repeat (idle) begin
            @(posedge clk_in);
            #1;
        end
        data_rx = value;
        data_ready_n = 1'b0;
        @(negedge clk_in);
        while (!ready_for_data) @(negedge clk_in);
        @(posedge clk_in);
        #1;
        data_ready_n = 1'b1;
    endtask

    task automatic wait_idle();
        forever begin
            @(posedge clk_in);
            #1;
            if (ready_for_data && quiet_cycles >= 2) break;
        end
    endtask

    initial begin
        int fd;
        int n;
        int line_no;
        string line;
        logic [7:0] tag;
        logic [7:0] a;
        logic [7:0] b;
        reset = 1'b1;
        data_rx = '0;
        data_ready_n = 1'b1;
        rand_state = 32'hc99b;
        cycle_count = 0;
        cycle_limit = 0;
        quiet_cycles = 0;
        for (int i = 0; i < FB_SIZE; i++) fb_model[i] = '0;

        fd = $fopen("tb_panel_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb_panel_input.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "missing stimulus file");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            line_no = line_no + 1;
            if (n > 1 && line.getc(0) != "#") begin
                a = '0;
                b = '0;
                n = $sscanf(line, "%c %h %h", tag, a, b);
                rec_tag.push_back(tag);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_line.push_back(line_no);
            end
        end
        $fclose(fd);
        cycle_limit = rec_tag.size() * 100;

        repeat (3) @(posedge clk_in);
        #1;
        reset = 1'b0;

        for (int i = 0; i < rec_tag.size(); i++) begin
            string name;
            name = $sformatf("record on line %0d", rec_line[i]);
            case (rec_tag[i])
                "S": send_byte(cmd_byte_t'(rec_a[i]));
                "R": check_rgb(name, rgb_enable_t'(rec_a[i][2:0]), rgb_enable);
                "B": check_brightness(name, brightness_t'(rec_a[i][5:0]), brightness_enable);
                "M": check_color(name, pixel_color_t'(rec_b[i]), fb_model[rec_a[i][5:0]]);
                "Q": wait_idle();
                "F": begin
                    for (int j = 0; j < FB_SIZE; j++) begin
                        check_color($sformatf("%s, address %0d", name, j),
                                    pixel_color_t'(rec_a[i]), fb_model[j]);
                    end
                end
                default: begin
                    $display("unknown tag in the stimulus file on line %0d", rec_line[i]);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "bad stimulus record");
                end
            endcase
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== panel_control_top.sv ====
// panel command controller top level
// decoder and framebuffer writer joined by the dispatch interface
`timescale 1ns/1ps

module panel_control_top (
    input  logic                       clk_in,
    input  logic                       reset,
    input  panel_cmd_pkg::cmd_byte_t   data_rx,
    input  logic                       data_ready_n,
    output logic                       ready_for_data,
    output panel_fb_pkg::rgb_enable_t  rgb_enable,
    output panel_fb_pkg::brightness_t  brightness_enable,
    output panel_fb_pkg::fb_addr_t     ram_address,
    output panel_fb_pkg::pixel_color_t ram_data,
    output logic                       ram_write_enable
);

    cmd_dispatch_if dispatch_bus ();

    cmd_decoder u_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .ready_for_data    (ready_for_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .dispatch          (dispatch_bus.issuer)
    );

    fb_writer u_writer (
        .clk_in           (clk_in),
        .reset            (reset),
        .dispatch         (dispatch_bus.engine),
        .ram_address      (ram_address),
        .ram_data         (ram_data),
        .ram_write_enable (ram_write_enable)
    );

endmodule

// ==== fb_writer.sv ====
// framebuffer write engine
// single pixel writes and full panel sweeps, one write per cycle
`timescale 1ns/1ps
`include "panel_settings.svh"

module fb_writer (
    input  logic                       clk_in,
    input  logic                       reset,
    cmd_dispatch_if.engine             dispatch,
    output panel_fb_pkg::fb_addr_t     ram_address,
    output panel_fb_pkg::pixel_color_t ram_data,
    output logic                       ram_write_enable
);
    import panel_fb_pkg::*;

    localparam fb_addr_t LAST_ADDR = fb_addr_t'(`PANEL_WIDTH * `PANEL_HEIGHT - 1);

    write_kind_t job_kind;
    logic last_write;

    // a pixel job ends after its only write, a fill after the top address
    assign last_write = (job_kind == WRITE_PIXEL) || (ram_address == LAST_ADDR);

    // busy exactly while writes are being shown on the bus
    assign dispatch.busy = ram_write_enable;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
            job_kind <= WRITE_PIXEL;
        end else if (dispatch.start) begin
            ram_write_enable <= 1'b1;
            job_kind <= dispatch.kind;
        end else if (ram_write_enable && last_write) begin
            ram_write_enable <= 1'b0;
        end
    end

    // address and colour of the write on the bus
    always_ff @(posedge clk_in) begin
        if (dispatch.start) begin
            ram_data <= dispatch.color;
            if (dispatch.kind == WRITE_FILL) begin
                ram_address <= '0;
            end else begin
                ram_address <= dispatch.addr;
            end
        end else if (ram_write_enable && !last_write) begin
            // fill sweep, colour stays latched
            ram_address <= ram_address + fb_addr_t'(1);
        end
    end

endmodule

// ==== cmd_decoder.sv ====
// byte stream handshake, opcode decode and argument collection
// holds the rgb and brightness enables, issues framebuffer write jobs
`timescale 1ns/1ps
`include "panel_settings.svh"

module cmd_decoder (
    input  logic                     clk_in,
    input  logic                     reset,
    input  panel_cmd_pkg::cmd_byte_t data_rx,
    input  logic                     data_ready_n,
    output logic                     ready_for_data,
    output panel_fb_pkg::rgb_enable_t rgb_enable,
    output panel_fb_pkg::brightness_t brightness_enable,
    cmd_dispatch_if.issuer           dispatch
);
    import panel_cmd_pkg::*;
    import panel_fb_pkg::*;

    typedef logic [$clog2(`BRIGHTNESS_LEVELS)-1:0] plane_idx_t;

    ctrl_state_t state;
    opcode_t opcode;
    logic accept;
    plane_idx_t plane_sel;
    fb_addr_t pixel_addr;

    // no new byte while a job is in flight
    assign ready_for_data = ~dispatch.busy;
    assign accept = ~data_ready_n && ready_for_data;
    assign opcode = opcode_t'(data_rx);

    // BRIGHTNESS_ONE hits the top plane, SIX the bottom one
    assign plane_sel = plane_idx_t'(`BRIGHTNESS_LEVELS - int'(data_rx[2:0]));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else if (accept) begin
            case (state)
                IDLE: begin
                    case (opcode)
                        RED_ENABLE: rgb_enable.red <= 1'b1;
                        RED_DISABLE: rgb_enable.red <= 1'b0;
                        GREEN_ENABLE: rgb_enable.green <= 1'b1;
                        GREEN_DISABLE: rgb_enable.green <= 1'b0;
                        BLUE_ENABLE: rgb_enable.blue <= 1'b1;
                        BLUE_DISABLE: rgb_enable.blue <= 1'b0;
                        BRIGHTNESS_ZERO: brightness_enable <= '0;
                        BRIGHTNESS_NINE: brightness_enable <= '1;
                        BRIGHTNESS_ONE, BRIGHTNESS_TWO, BRIGHTNESS_THREE,
                        BRIGHTNESS_FOUR, BRIGHTNESS_FIVE, BRIGHTNESS_SIX: begin
                            brightness_enable[plane_sel] <= ~brightness_enable[plane_sel];
                        end
                        READBRIGHTNESS: state <= WAIT_BRIGHTNESS;
                        READPIXEL: state <= WAIT_PIXEL_ADDR;
                        FILLPANEL: state <= WAIT_FILL_COLOR;
                        // blankpanel goes straight out as a job, unknown bytes are dropped
                        default: begin
                        end
                    endcase
                end
                WAIT_BRIGHTNESS: begin
                    brightness_enable <= data_rx[`BRIGHTNESS_LEVELS-1:0];
                    state <= IDLE;
                end
                WAIT_PIXEL_ADDR: state <= WAIT_PIXEL_COLOR;
                WAIT_PIXEL_COLOR: state <= IDLE;
                WAIT_FILL_COLOR: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address byte of readpixel, used with the colour byte that follows
    always_ff @(posedge clk_in) begin
        if (accept && state == WAIT_PIXEL_ADDR) begin
            pixel_addr <= fb_addr_t'(data_rx);
        end
    end

    // job goes out in the same cycle as its last byte is accepted
    always_comb begin
        dispatch.start = 1'b0;
        dispatch.kind = WRITE_PIXEL;
        dispatch.addr = pixel_addr;
        dispatch.color = pixel_color_t'(data_rx);
        if (accept) begin
            case (state)
                IDLE: begin
                    if (opcode == BLANKPANEL) begin
                        dispatch.start = 1'b1;
                        dispatch.kind = WRITE_FILL;
                        dispatch.color = '0;
                    end
                end
                WAIT_PIXEL_COLOR: begin
                    dispatch.start = 1'b1;
                end
                WAIT_FILL_COLOR: begin
                    dispatch.start = 1'b1;
                    dispatch.kind = WRITE_FILL;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== cmd_dispatch_if.sv ====
// write job handoff from the command decoder to the framebuffer writer
`timescale 1ns/1ps

interface cmd_dispatch_if;
    import panel_fb_pkg::*;

    // one-cycle pulse, only while busy is low
    logic start;
    write_kind_t kind;
    fb_addr_t addr;
    pixel_color_t color;
    // high from the cycle after start until the last write
    logic busy;

    modport issuer (
        output start,
        output kind,
        output addr,
        output color,
        input  busy
    );

    modport engine (
        input  start,
        input  kind,
        input  addr,
        input  color,
        output busy
    );

endinterface

// ==== panel_fb_pkg.sv ====
// framebuffer types: address, colour, rgb enables, brightness, write kind
`include "panel_settings.svh"

package panel_fb_pkg;

    typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;

    typedef logic [`COLOR_BITS-1:0] pixel_color_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_enable_t;

    // one enable bit per bit-plane
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

    // single pixel or sweep over the whole panel
    typedef enum logic {
        WRITE_PIXEL,
        WRITE_FILL
    } write_kind_t;

endpackage

// ==== panel_cmd_pkg.sv ====
// command stream types: stream byte, opcodes, decoder states
package panel_cmd_pkg;

    // one byte of the incoming stream, opcode or argument
    typedef logic [7:0] cmd_byte_t;

    typedef enum logic [7:0] {
        RED_ENABLE       = 8'h01,
        RED_DISABLE      = 8'h02,
        GREEN_ENABLE     = 8'h03,
        GREEN_DISABLE    = 8'h04,
        BLUE_ENABLE      = 8'h05,
        BLUE_DISABLE     = 8'h06,
        BRIGHTNESS_ZERO  = 8'h10,
        BRIGHTNESS_ONE   = 8'h11,
        BRIGHTNESS_TWO   = 8'h12,
        BRIGHTNESS_THREE = 8'h13,
        BRIGHTNESS_FOUR  = 8'h14,
        BRIGHTNESS_FIVE  = 8'h15,
        BRIGHTNESS_SIX   = 8'h16,
        BRIGHTNESS_NINE  = 8'h19,
        READBRIGHTNESS   = 8'h20,
        BLANKPANEL       = 8'h21,
        FILLPANEL        = 8'h22,
        READPIXEL        = 8'h23
    } opcode_t;

    // wait states name the argument byte expected next
    typedef enum logic [2:0] {
        IDLE,
        WAIT_BRIGHTNESS,
        WAIT_PIXEL_ADDR,
        WAIT_PIXEL_COLOR,
        WAIT_FILL_COLOR
    } ctrl_state_t;

endpackage

// ==== panel_settings.svh ====
// panel geometry, colour depth and brightness plane count
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// 8x8 panel
`define PANEL_WIDTH 8
`define PANEL_HEIGHT 8

// enough bits to address every pixel of the panel
`define FB_ADDR_BITS 6

// one byte per pixel
`define COLOR_BITS 8

// bit-planes of the brightness mask, top plane is the most significant
`define BRIGHTNESS_LEVELS 6

`endif
